// ==== hw/wb_pkg.sv ====
/* Default widths and counts for the shared-memory subsystem.
   Word widths must be a multiple of 8, with at least two byte lanes. */
package wb_pkg;

	// Defaults that the top level passes down.
	localparam int DEF_ARCHBITSZ = 32;
	localparam int DEF_MASTERCOUNT = 3;
	localparam int DEF_MEM_WORDS = 256;

	// Byte lanes in one word.
	function automatic int lane_count(input int width);
		return width / 8;
	endfunction

	// Word address width, the byte offset bits dropped.
	function automatic int addr_bits(input int width);
		return width - $clog2(lane_count(width));
	endfunction

	// Index width, never below one bit.
	function automatic int idx_bits(input int count);
		int bits;
		bits = $clog2(count);
		return (bits < 1) ? 1 : bits;
	endfunction

endpackage

// ==== hw/wb_arbiter.sv ====
`timescale 1ns/1ps

/* Round-robin arbiter for one slave. A granted master keeps the slave until it drops cyc,
   and the grant latency varies by up to MASTERCOUNT cycles. */
module wb_arbiter #(
	parameter int ARCHBITSZ = wb_pkg::DEF_ARCHBITSZ,
	parameter int MASTERCOUNT = wb_pkg::DEF_MASTERCOUNT
) (
	input  logic clk_i,
	input  logic rst_i,

	input  logic [MASTERCOUNT-1:0] m_wb_cyc_i,
	input  logic [MASTERCOUNT-1:0] m_wb_stb_i,
	input  logic [MASTERCOUNT-1:0] m_wb_we_i,
	input  logic [wb_pkg::addr_bits(ARCHBITSZ)*MASTERCOUNT-1:0] m_wb_addr_i,
	input  logic [wb_pkg::lane_count(ARCHBITSZ)*MASTERCOUNT-1:0] m_wb_sel_i,
	input  logic [ARCHBITSZ*MASTERCOUNT-1:0] m_wb_dat_i,
	output logic [MASTERCOUNT-1:0] m_wb_bsy_o,
	output logic [MASTERCOUNT-1:0] m_wb_ack_o,
	output logic [ARCHBITSZ*MASTERCOUNT-1:0] m_wb_dat_o,

	output logic s_wb_cyc_o,
	output logic s_wb_stb_o,
	output logic s_wb_we_o,
	output logic [wb_pkg::addr_bits(ARCHBITSZ)-1:0] s_wb_addr_o,
	output logic [wb_pkg::lane_count(ARCHBITSZ)-1:0] s_wb_sel_o,
	output logic [ARCHBITSZ-1:0] s_wb_dat_o,
	input  logic s_wb_bsy_i,
	input  logic s_wb_ack_i,
	input  logic [ARCHBITSZ-1:0] s_wb_dat_i
);
	import wb_pkg::*;

	localparam int ADDRBITSZ = addr_bits(ARCHBITSZ);
	localparam int SELBITSZ = lane_count(ARCHBITSZ);
	localparam int IDXBITSZ = idx_bits(MASTERCOUNT);
	localparam logic [IDXBITSZ-1:0] LAST_IDX = IDXBITSZ'(MASTERCOUNT - 1);

	logic [IDXBITSZ-1:0] mstridx;
	logic [IDXBITSZ-1:0] mstrhi;
	logic [IDXBITSZ-1:0] mstrloidx;
	logic [IDXBITSZ-1:0] mstrlonxt;
	logic [IDXBITSZ-1:0] mstrhiidx;
	logic [IDXBITSZ-1:0] mstrhinxt;

	logic [ADDRBITSZ-1:0] m_addr [MASTERCOUNT];
	logic [SELBITSZ-1:0]  m_sel  [MASTERCOUNT];
	logic [ARCHBITSZ-1:0] m_dat  [MASTERCOUNT];

	// ------------------------------------------------------------
	// Master side.
	// ------------------------------------------------------------

	// Ack and read data are broadcast, bsy shields every master but the granted one.
	for (genvar k = 0; k < MASTERCOUNT; k++) begin : gen_mstr
		assign m_addr[k] = m_wb_addr_i[k*ADDRBITSZ +: ADDRBITSZ];
		assign m_sel[k] = m_wb_sel_i[k*SELBITSZ +: SELBITSZ];
		assign m_dat[k] = m_wb_dat_i[k*ARCHBITSZ +: ARCHBITSZ];
		assign m_wb_bsy_o[k] = (mstridx == IDXBITSZ'(k)) ? s_wb_bsy_i : 1'b1;
		assign m_wb_ack_o[k] = s_wb_ack_i;
		assign m_wb_dat_o[k*ARCHBITSZ +: ARCHBITSZ] = s_wb_dat_i;
	end

	// Slave side follows the grant with no register in between.
	assign s_wb_cyc_o = m_wb_cyc_i[mstridx];
	assign s_wb_stb_o = m_wb_stb_i[mstridx];
	assign s_wb_we_o = m_wb_we_i[mstridx];
	assign s_wb_addr_o = m_addr[mstridx];
	assign s_wb_sel_o = m_sel[mstridx];
	assign s_wb_dat_o = m_dat[mstridx];

	// ------------------------------------------------------------
	// Scanners and grant.
	// ------------------------------------------------------------

	// Lowest active master, scanning upward one index per cycle.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mstrloidx <= '0;
			mstrlonxt <= '0;
		end else if (mstrloidx == LAST_IDX || m_wb_cyc_i[mstrloidx]) begin
			if (m_wb_cyc_i[mstrloidx])
				mstrlonxt <= mstrloidx;
			mstrloidx <= '0;
		end else begin
			mstrloidx <= mstrloidx + 1'b1;
		end
	end

	// Highest active master, scanning downward.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mstrhiidx <= LAST_IDX;
			mstrhinxt <= LAST_IDX;
		end else if (mstrhiidx == '0 || m_wb_cyc_i[mstrhiidx]) begin
			if (m_wb_cyc_i[mstrhiidx])
				mstrhinxt <= mstrhiidx;
			mstrhiidx <= LAST_IDX;
		end else begin
			mstrhiidx <= mstrhiidx - 1'b1;
		end
	end

	// Grant moves on only once the current master has let go of cyc.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mstridx <= '0;
			mstrhi <= LAST_IDX;
		end else if (!m_wb_cyc_i[mstridx]) begin
			if (mstridx < mstrhi) begin
				mstridx <= mstridx + 1'b1;
			end else begin
				// Wrap to the low end of the active range.
				mstridx <= mstrlonxt;
				mstrhi <= mstrhinxt;
			end
		end
	end

	// The grant must point at an existing master.
	a_grant_range: assert property (@(posedge clk_i) disable iff (rst_i)
		int'(mstridx) < MASTERCOUNT);

	// A bridge raises stb only inside its own cycle.
	a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		s_wb_stb_o |-> s_wb_cyc_o);

endmodule

// ==== hw/wb_req_bridge.sv ====
`timescale 1ns/1ps

/* Four-phase host port to one Wishbone single-word cycle. The host holds req and the
   command stable until ack_o rises, and raises req again only once ack_o is low. */
module wb_req_bridge #(
	parameter int ARCHBITSZ = wb_pkg::DEF_ARCHBITSZ
) (
	input  logic clk_i,
	input  logic rst_i,

	input  logic req_i,
	input  logic we_i,
	input  logic [wb_pkg::addr_bits(ARCHBITSZ)-1:0] addr_i,
	input  logic [wb_pkg::lane_count(ARCHBITSZ)-1:0] sel_i,
	input  logic [ARCHBITSZ-1:0] wdat_i,
	output logic ack_o,
	output logic [ARCHBITSZ-1:0] rdat_o,

	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output logic [wb_pkg::addr_bits(ARCHBITSZ)-1:0] wb_addr_o,
	output logic [wb_pkg::lane_count(ARCHBITSZ)-1:0] wb_sel_o,
	output logic [ARCHBITSZ-1:0] wb_dat_o,
	input  logic wb_bsy_i,
	input  logic wb_ack_i,
	input  logic [ARCHBITSZ-1:0] wb_dat_i
);
	import wb_pkg::*;

	localparam int ADDRBITSZ = addr_bits(ARCHBITSZ);
	localparam int SELBITSZ = lane_count(ARCHBITSZ);

	// FSM states.
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_REQ  = 2'd1;
	localparam logic [1:0] ST_WAIT = 2'd2;
	localparam logic [1:0] ST_DONE = 2'd3;

	logic [1:0] state_q;

	logic                 we_q;
	logic [ADDRBITSZ-1:0] addr_q;
	logic [SELBITSZ-1:0]  sel_q;
	logic [ARCHBITSZ-1:0] wdat_q;
	logic [ARCHBITSZ-1:0] rdat_q;

	// ------------------------------------------------------------
	// Command and read data.
	// ------------------------------------------------------------

	// Command is taken once, on the rising req.
	always_ff @(posedge clk_i) begin
		if (state_q == ST_IDLE && req_i) begin
			we_q <= we_i;
			addr_q <= addr_i;
			sel_q <= sel_i;
			wdat_q <= wdat_i;
		end
	end

	// Ack is broadcast, so only one seen after our own acceptance counts.
	always_ff @(posedge clk_i) begin
		if (state_q == ST_WAIT && wb_ack_i)
			rdat_q <= wb_dat_i;
	end

	// ------------------------------------------------------------
	// Handshake FSM.
	// ------------------------------------------------------------

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (req_i)
						state_q <= ST_REQ;
				end
				ST_REQ: begin
					// Accepted when stb is high and bsy is low.
					if (!wb_bsy_i)
						state_q <= ST_WAIT;
				end
				ST_WAIT: begin
					if (wb_ack_i)
						state_q <= ST_DONE;
				end
				ST_DONE: begin
					// cyc is already low, a slow host blocks no one here.
					if (!req_i)
						state_q <= ST_IDLE;
				end
			endcase
		end
	end

	assign wb_cyc_o = (state_q == ST_REQ) || (state_q == ST_WAIT);
	assign wb_stb_o = (state_q == ST_REQ);
	assign wb_we_o = we_q;
	assign wb_addr_o = addr_q;
	assign wb_sel_o = sel_q;
	assign wb_dat_o = wdat_q;

	assign ack_o = (state_q == ST_DONE);
	assign rdat_o = rdat_q;

	// The host keeps req up until the command has completed.
	a_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
		(state_q == ST_REQ || state_q == ST_WAIT) |-> req_i);

endmodule

// ==== hw/wb_ram.sv ====
`timescale 1ns/1ps

/* Byte-lane RAM slave, one access at a time with ack two cycles after acceptance.
   Addresses wrap modulo MEM_WORDS and reset leaves the contents as they are. */
module wb_ram #(
	parameter int ARCHBITSZ = wb_pkg::DEF_ARCHBITSZ,
	parameter int MEM_WORDS = wb_pkg::DEF_MEM_WORDS
) (
	input  logic clk_i,
	input  logic rst_i,

	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [wb_pkg::addr_bits(ARCHBITSZ)-1:0] wb_addr_i,
	input  logic [wb_pkg::lane_count(ARCHBITSZ)-1:0] wb_sel_i,
	input  logic [ARCHBITSZ-1:0] wb_dat_i,
	output logic wb_bsy_o,
	output logic wb_ack_o,
	output logic [ARCHBITSZ-1:0] wb_dat_o
);
	import wb_pkg::*;

	localparam int ADDRBITSZ = addr_bits(ARCHBITSZ);
	localparam int LANES = lane_count(ARCHBITSZ);
	localparam int WIDXBITSZ = idx_bits(MEM_WORDS);

	logic [ARCHBITSZ-1:0] mem [MEM_WORDS];

	logic                 accept;
	logic [WIDXBITSZ-1:0] word_idx;
	logic [1:0]           pend_q;
	logic [ARCHBITSZ-1:0] rd_stage_q;
	logic [ARCHBITSZ-1:0] dat_q;

	assign accept = wb_cyc_i && wb_stb_i && !wb_bsy_o;
	assign word_idx = WIDXBITSZ'(wb_addr_i % ADDRBITSZ'(MEM_WORDS));

	// ------------------------------------------------------------
	// Pending pipe.
	// ------------------------------------------------------------

	// Stage 0 is the array read, stage 1 the output register.
	always_ff @(posedge clk_i) begin
		if (rst_i)
			pend_q <= '0;
		else
			pend_q <= {pend_q[0], accept};
	end

	assign wb_bsy_o = |pend_q;
	assign wb_ack_o = pend_q[1];

	// ------------------------------------------------------------
	// Array and read path.
	// ------------------------------------------------------------

	always_ff @(posedge clk_i) begin
		if (accept) begin
			rd_stage_q <= mem[word_idx];
			if (wb_we_i) begin
				for (int b = 0; b < LANES; b++) begin
					if (wb_sel_i[b])
						mem[word_idx][b*8 +: 8] <= wb_dat_i[b*8 +: 8];
				end
			end
		end
	end

	// Valid in the ack cycle.
	always_ff @(posedge clk_i) begin
		if (pend_q[0])
			dat_q <= rd_stage_q;
	end

	assign wb_dat_o = dat_q;

	// Every ack pulse follows an acceptance two cycles before and lands while the master holds cyc.
	a_ack_after_accept: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(wb_ack_o) |-> $past(accept, 2) && wb_cyc_i);

endmodule

// ==== hw/wb_subsys_top.sv ====
`timescale 1ns/1ps

/* Shared RAM behind a round-robin arbiter, with one four-phase host port per master.
   Single-word commands only, so there are no bursts and no error responses. */
module wb_subsys_top #(
	parameter int ARCHBITSZ = wb_pkg::DEF_ARCHBITSZ,
	parameter int MASTERCOUNT = wb_pkg::DEF_MASTERCOUNT,
	parameter int MEM_WORDS = wb_pkg::DEF_MEM_WORDS
) (
	input  logic clk_i,
	input  logic rst_i,

	input  logic [MASTERCOUNT-1:0] req_i,
	input  logic [MASTERCOUNT-1:0] we_i,
	input  logic [wb_pkg::addr_bits(ARCHBITSZ)*MASTERCOUNT-1:0] addr_i,
	input  logic [wb_pkg::lane_count(ARCHBITSZ)*MASTERCOUNT-1:0] sel_i,
	input  logic [ARCHBITSZ*MASTERCOUNT-1:0] wdat_i,
	output logic [MASTERCOUNT-1:0] ack_o,
	output logic [ARCHBITSZ*MASTERCOUNT-1:0] rdat_o
);
	import wb_pkg::*;

	localparam int ADDRBITSZ = addr_bits(ARCHBITSZ);
	localparam int SELBITSZ = lane_count(ARCHBITSZ);

	// Master buses, packed by port index.
	logic [MASTERCOUNT-1:0]           m_cyc;
	logic [MASTERCOUNT-1:0]           m_stb;
	logic [MASTERCOUNT-1:0]           m_we;
	logic [ADDRBITSZ*MASTERCOUNT-1:0] m_addr;
	logic [SELBITSZ*MASTERCOUNT-1:0]  m_sel;
	logic [ARCHBITSZ*MASTERCOUNT-1:0] m_dat;
	logic [MASTERCOUNT-1:0]           m_bsy;
	logic [MASTERCOUNT-1:0]           m_ack;
	logic [ARCHBITSZ*MASTERCOUNT-1:0] m_rdat;

	// Slave bus.
	logic                 s_cyc;
	logic                 s_stb;
	logic                 s_we;
	logic [ADDRBITSZ-1:0] s_addr;
	logic [SELBITSZ-1:0]  s_sel;
	logic [ARCHBITSZ-1:0] s_dat;
	logic                 s_bsy;
	logic                 s_ack;
	logic [ARCHBITSZ-1:0] s_rdat;

	// ------------------------------------------------------------
	// One bridge per host port.
	// ------------------------------------------------------------

	for (genvar k = 0; k < MASTERCOUNT; k++) begin : gen_port
		wb_req_bridge #(
			.ARCHBITSZ(ARCHBITSZ)
		) u_bridge (
			.clk_i(clk_i),
			.rst_i(rst_i),
			.req_i(req_i[k]),
			.we_i(we_i[k]),
			.addr_i(addr_i[k*ADDRBITSZ +: ADDRBITSZ]),
			.sel_i(sel_i[k*SELBITSZ +: SELBITSZ]),
			.wdat_i(wdat_i[k*ARCHBITSZ +: ARCHBITSZ]),
			.ack_o(ack_o[k]),
			.rdat_o(rdat_o[k*ARCHBITSZ +: ARCHBITSZ]),
			.wb_cyc_o(m_cyc[k]),
			.wb_stb_o(m_stb[k]),
			.wb_we_o(m_we[k]),
			.wb_addr_o(m_addr[k*ADDRBITSZ +: ADDRBITSZ]),
			.wb_sel_o(m_sel[k*SELBITSZ +: SELBITSZ]),
			.wb_dat_o(m_dat[k*ARCHBITSZ +: ARCHBITSZ]),
			.wb_bsy_i(m_bsy[k]),
			.wb_ack_i(m_ack[k]),
			.wb_dat_i(m_rdat[k*ARCHBITSZ +: ARCHBITSZ])
		);
	end

	// ------------------------------------------------------------
	// Arbiter and RAM.
	// ------------------------------------------------------------

	wb_arbiter #(
		.ARCHBITSZ(ARCHBITSZ),
		.MASTERCOUNT(MASTERCOUNT)
	) u_arbiter (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.m_wb_cyc_i(m_cyc),
		.m_wb_stb_i(m_stb),
		.m_wb_we_i(m_we),
		.m_wb_addr_i(m_addr),
		.m_wb_sel_i(m_sel),
		.m_wb_dat_i(m_dat),
		.m_wb_bsy_o(m_bsy),
		.m_wb_ack_o(m_ack),
		.m_wb_dat_o(m_rdat),
		.s_wb_cyc_o(s_cyc),
		.s_wb_stb_o(s_stb),
		.s_wb_we_o(s_we),
		.s_wb_addr_o(s_addr),
		.s_wb_sel_o(s_sel),
		.s_wb_dat_o(s_dat),
		.s_wb_bsy_i(s_bsy),
		.s_wb_ack_i(s_ack),
		.s_wb_dat_i(s_rdat)
	);

	wb_ram #(
		.ARCHBITSZ(ARCHBITSZ),
		.MEM_WORDS(MEM_WORDS)
	) u_ram (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.wb_cyc_i(s_cyc),
		.wb_stb_i(s_stb),
		.wb_we_i(s_we),
		.wb_addr_i(s_addr),
		.wb_sel_i(s_sel),
		.wb_dat_i(s_dat),
		.wb_bsy_o(s_bsy),
		.wb_ack_o(s_ack),
		.wb_dat_o(s_rdat)
	);

endmodule

// ==== verification/wb_subsys_tb.sv ====
`timescale 1ns/1ps

/* Testbench for the shared RAM subsystem. The RAM is filled through the host ports
   before any read, and the run stops at the first mismatch or timeout. */
module wb_subsys_tb;
	import wb_pkg::*;

	localparam int DW = DEF_ARCHBITSZ;
	localparam int NP = DEF_MASTERCOUNT;
	localparam int WORDS = DEF_MEM_WORDS;
	localparam int ADDRW = addr_bits(DW);
	localparam int SELW = lane_count(DW);
	localparam int TIMEOUT = 64;

	logic clk_i = 1'b0;
	logic rst_i;
	logic [NP-1:0] req_i;
	logic [NP-1:0] we_i;
	logic [ADDRW*NP-1:0] addr_i;
	logic [SELW*NP-1:0] sel_i;
	logic [DW*NP-1:0] wdat_i;
	logic [NP-1:0] ack_o;
	logic [DW*NP-1:0] rdat_o;

	logic [31:0] lfsr_q = 32'h5261;
	logic [DW-1:0] shadow [WORDS];
	logic [DW-1:0] exp_rdat [NP];
	int rd_issued [NP];
	int rd_checked [NP];

	wb_subsys_top #(
		.ARCHBITSZ(DW),
		.MASTERCOUNT(NP),
		.MEM_WORDS(WORDS)
	) UUT (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.req_i(req_i),
		.we_i(we_i),
		.addr_i(addr_i),
		.sel_i(sel_i),
		.wdat_i(wdat_i),
		.ack_o(ack_o),
		.rdat_o(rdat_o)
	);

	always #10 clk_i = ~clk_i;

	// ------------------------------------------------------------
	// Reference model and checks.
	// ------------------------------------------------------------

	// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] next_random(input int nbits);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
			val = {val[30:0], lfsr_q[0]};
		end
		return val;
	endfunction

	// Merges a write by byte lane and returns the word a read sees.
	function automatic logic [DW-1:0] ref_access(input logic w, input logic [ADDRW-1:0] a,
			input logic [SELW-1:0] s, input logic [DW-1:0] d);
		int idx;
		idx = int'(a % ADDRW'(WORDS));
		if (w) begin
			for (int b = 0; b < SELW; b++)
				if (s[b])
					shadow[idx][b*8 +: 8] = d[b*8 +: 8];
		end
		return shadow[idx];
	endfunction

	task automatic fail_run();
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [DW-1:0] exp,
			input logic [DW-1:0] act);
		if (act !== exp) begin
			$display("Error: %s expected 0x%h, got 0x%h", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error: %s expected 0x%h, got 0x%h", name, exp, act);
			fail_run();
		end
	endtask

	// Read data is compared in the middle of the ack_o high phase.
	always @(negedge clk_i) begin
		for (int k = 0; k < NP; k++) begin
			if (ack_o[k] === 1'b1 && rd_checked[k] != rd_issued[k]) begin
				check_word($sformatf("rdat_o[%0d]", k), exp_rdat[k], rdat_o[k*DW +: DW]);
				rd_checked[k] = rd_checked[k] + 1;
			end
		end
	end

	// ------------------------------------------------------------
	// Host port driver.
	// ------------------------------------------------------------

	task automatic wait_ack(input int p, input logic level);
		int n;
		n = 0;
		while (ack_o[p] !== level && n < TIMEOUT) begin
			@(posedge clk_i);
			#2;
			n++;
		end
		if (ack_o[p] !== level) begin
			$display("Timeout: ack_o[%0d] did not go to %0b within %0d cycles", p, level, TIMEOUT);
			fail_run();
		end
	endtask

	// One four-phase command, with req held for hold extra cycles after ack_o.
	task automatic host_cmd(input int p, input logic w, input logic [ADDRW-1:0] a,
			input logic [SELW-1:0] s, input logic [DW-1:0] d, input int hold);
		logic [DW-1:0] exp;
		@(posedge clk_i);
		#2;
		exp = ref_access(w, a, s, d);
		if (!w) begin
			exp_rdat[p] = exp;
			rd_issued[p]++;
		end
		we_i[p] = w;
		addr_i[p*ADDRW +: ADDRW] = a;
		sel_i[p*SELW +: SELW] = s;
		wdat_i[p*DW +: DW] = d;
		req_i[p] = 1'b1;
		wait_ack(p, 1'b1);
		repeat (hold) begin
			@(posedge clk_i);
			#2;
			check_bit($sformatf("ack_o[%0d]", p), 1'b1, ack_o[p]);
		end
		req_i[p] = 1'b0;
		wait_ack(p, 1'b0);
	endtask

	initial begin
		logic [DW-1:0] wd [NP];
		logic [ADDRW-1:0] a0, a1;
		logic [SELW-1:0] s0, s1;
		logic [DW-1:0] d0, d1;
		logic w0, w1;
		int pa, pb;

		rst_i = 1'b1;
		req_i = '0;
		we_i = '0;
		addr_i = '0;
		sel_i = '0;
		wdat_i = '0;
		repeat (8) @(posedge clk_i);
		#2;
		rst_i = 1'b0;

		// Idle ports never see ack.
		repeat (10) begin
			@(posedge clk_i);
			#2;
			for (int k = 0; k < NP; k++)
				check_bit($sformatf("ack_o[%0d]", k), 1'b0, ack_o[k]);
		end

		for (int i = 0; i < WORDS; i++)
			host_cmd(i % NP, 1'b1, ADDRW'(i), '1,
				DW'(i * 32'h0100_0193) ^ DW'(32'h5A5A_C3C3), 0);

		d0 = DW'(next_random(DW));
		host_cmd(0, 1'b1, ADDRW'(7), '1, d0, 0);
		host_cmd(0, 1'b0, ADDRW'(7), '1, '0, 0);

		// Each port writes its own lane of one word.
		for (int k = 0; k < NP; k++)
			host_cmd(k, 1'b1, ADDRW'(40), SELW'(1 << k), DW'(next_random(DW)), 0);
		for (int k = 0; k < NP; k++)
			host_cmd(k, 1'b0, ADDRW'(40), '1, '0, 0);

		// All ports at once, then read back from a neighbour port.
		for (int k = 0; k < NP; k++)
			wd[k] = DW'(next_random(DW));
		for (int k = 0; k < NP; k++) begin
			fork
				automatic int p = k;
				host_cmd(p, 1'b1, ADDRW'(64 + p), '1, wd[p], 0);
			join_none
		end
		wait fork;
		for (int k = 0; k < NP; k++) begin
			fork
				automatic int p = k;
				host_cmd((p + 1) % NP, 1'b0, ADDRW'(64 + p), '1, '0, 0);
			join_none
		end
		wait fork;

		// Slow hosts hold req after ack_o.
		for (int i = 0; i < 6; i++)
			host_cmd(i % NP, 1'b0, ADDRW'(next_random(8)), '1, '0, int'(next_random(3)) + 1);

		// Two ports per round, one on each half of the RAM.
		for (int i = 0; i < 100; i++) begin
			pa = int'(next_random(8) % NP);
			pb = (pa + 1 + int'(next_random(8) % (NP - 1))) % NP;
			w0 = 1'(next_random(1));
			w1 = 1'(next_random(1));
			a0 = ADDRW'(next_random(16)) * ADDRW'(WORDS) + ADDRW'(next_random(8) % (WORDS / 2));
			a1 = ADDRW'(next_random(16)) * ADDRW'(WORDS) + ADDRW'(next_random(8) % (WORDS / 2))
				+ ADDRW'(WORDS / 2);
			s0 = SELW'(next_random(SELW));
			s1 = SELW'(next_random(SELW));
			d0 = DW'(next_random(DW));
			d1 = DW'(next_random(DW));
			fork
				host_cmd(pa, w0, a0, s0, d0, 0);
				host_cmd(pb, w1, a1, s1, d1, 0);
			join
		end

		if (rd_checked.sum() == rd_issued.sum()) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("Some read data was never compared against the shadow memory");
			fail_run();
		end
	end

endmodule

// ==== wb_subsys_top.f ====
hw/wb_pkg.sv
hw/wb_arbiter.sv
hw/wb_req_bridge.sv
hw/wb_ram.sv
hw/wb_subsys_top.sv
verification/wb_subsys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for a failure.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f wb_subsys_top.f --top-module wb_subsys_tb -o wb_subsys_sim

./obj_dir/wb_subsys_sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation passed"
